// File: include/pktbuf_cfg.svh
// Sizing of the packet buffer manager.
// Include this header in any file that needs the buffer, port or credit counts.
`ifndef PKTBUF_CFG_SVH
`define PKTBUF_CFG_SVH

// ******************************
// buffer pool
// ******************************
// must stay a power of two
`define PKTBUF_BUF_NUM      16
`define PKTBUF_BPTR_NBITS   4

// ******************************
// write ports and release path
// ******************************
`define PKTBUF_NUM_PORTS    4
`define PKTBUF_PORT_NBITS   2
// release queue depth, equal to the initial sender credits
`define PKTBUF_REL_CREDITS  4

`endif

// File: logic/pktbuf_pkg.sv
// Shared types of the packet buffer manager.
// Widths come from the sizing header. Modules import this package.
`include "pktbuf_cfg.svh"

package pktbuf_pkg;

    typedef logic [`PKTBUF_BPTR_NBITS-1:0] buf_ptr_t;
    typedef logic [`PKTBUF_PORT_NBITS-1:0] port_id_t;

    typedef struct packed {
        buf_ptr_t ptr;
        port_id_t port;
    } rel_req_t;

    typedef struct packed {
        buf_ptr_t ptr;
        port_id_t port;
        logic     sop;      // first buffer of a packet
    } wr_evt_t;

    typedef struct packed {
        buf_ptr_t prev;
        buf_ptr_t cur;
    } enq_evt_t;

    // ******************************
    // register bus
    // ******************************
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [3:0]  addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } reg_rsp_t;

    typedef enum logic [3:0] {
        REG_CTRL      = 4'd0,
        REG_STATUS    = 4'd1,
        REG_ALLOC_CNT = 4'd2,
        REG_REL_CNT   = 4'd3
    } reg_addr_e;

endpackage

// File: logic/sync_fifo.sv
// Synchronous register-array FIFO. The payload type is set by parameter T.
// dout shows the head entry while empty is low, so it is first-word fall-through.
// A write while full and a read while empty are both ignored.
`timescale 1ns/10ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4,
    parameter int  CNT_W = $clog2(DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr,
    input  T                 din,
    input  logic             rd,
    output T                 dout,
    output logic [CNT_W-1:0] count,
    output logic             full,
    output logic             almost_full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    // wraps at DEPTH, so any depth works
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        logic [AW-1:0] nxt;
        nxt = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
        return nxt;
    endfunction

    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    // ******************************
    // pointers and occupancy
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    // ******************************
    // storage
    // ******************************
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    assign dout        = mem[rd_ptr];                   // head entry
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count == CNT_W'(DEPTH - 1));  // one slot left
    assign empty       = (count == '0);

endmodule

// File: logic/freeb_ctrl.sv
// Free buffer control. After reset or init_cmd it fills the free list with
// pointers 0 to BUF_NUM-1, then drains release queue heads back into it.
// A two-entry prefetch FIFO answers allocation requests 2 cycles later.
// Write events are turned into prev/cur link events for the link table.
`timescale 1ns/10ps
`include "pktbuf_cfg.svh"

module freeb_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 init_cmd,
    input  logic                 free_buf_req,
    output logic                 free_buf_valid,
    output logic                 free_buf_available,
    output pktbuf_pkg::buf_ptr_t free_buf_ptr,
    input  logic                 wr_valid,
    input  pktbuf_pkg::wr_evt_t  wr_evt,
    output logic                 enq_valid,
    output pktbuf_pkg::enq_evt_t enq_evt,
    input  logic                 rel_empty,
    input  pktbuf_pkg::rel_req_t rel_head,
    output logic                 rel_pop,
    output logic                 init_done,
    output logic                 alloc_inc,
    output logic                 rel_inc
);
    import pktbuf_pkg::*;

    localparam int BUF_NUM  = `PKTBUF_BUF_NUM;
    localparam int NPORTS   = `PKTBUF_NUM_PORTS;
    localparam int LIST_CW  = $clog2(BUF_NUM + 1);
    localparam int PF_DEPTH = 2;

    typedef enum logic [1:0] {
        INIT_IDLE,
        INIT_RESET,
        INIT_FILL,
        INIT_DONE
    } init_st_e;

    init_st_e           init_st;
    init_st_e           nxt_init_st;
    logic               list_rst;       // clears list and prefetch
    logic               fill_wr;        // writing the init sequence
    logic               list_wr;
    logic               list_rd;
    logic               list_rd_d1;
    logic               list_full;
    logic               list_empty;
    logic [LIST_CW-1:0] list_count;
    buf_ptr_t           list_din;
    buf_ptr_t           list_dout;
    buf_ptr_t           list_dout_q;
    logic               pf_rd;
    logic               pf_full;
    logic               pf_almost_full;
    logic               pf_empty;
    logic               pf_room;
    buf_ptr_t           pf_dout;
    logic               req_d1;
    logic               wr_valid_d1;
    wr_evt_t            wr_evt_d1;
    buf_ptr_t           last_ptr [NPORTS];

    // ******************************
    // init state machine
    // ******************************
    always_comb begin
        nxt_init_st = init_st;
        case (init_st)
            INIT_IDLE:  nxt_init_st = INIT_RESET;
            INIT_RESET: nxt_init_st = INIT_FILL;
            INIT_FILL: begin
                if (list_count == LIST_CW'(BUF_NUM - 1))   // last pointer this cycle
                    nxt_init_st = INIT_DONE;
            end
            INIT_DONE: begin
                if (init_cmd)
                    nxt_init_st = INIT_IDLE;
            end
            default:    nxt_init_st = INIT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init_st   <= INIT_IDLE;
            list_rst  <= 1'b1;
            fill_wr   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            init_st   <= nxt_init_st;
            list_rst  <= (nxt_init_st == INIT_RESET);
            fill_wr   <= (nxt_init_st == INIT_FILL);
            init_done <= (nxt_init_st == INIT_DONE);
        end
    end

    // ******************************
    // free list and prefetch
    // ******************************
    assign rel_pop  = init_done & ~rel_empty & ~list_full;
    assign list_wr  = fill_wr | rel_pop;
    assign list_din = fill_wr ? buf_ptr_t'(list_count) : rel_head.ptr;   // count = next index

    // prefetch may not exceed two entries once the pending write lands
    assign pf_room = pf_full ? (pf_rd & ~list_rd_d1)
                             : ~(pf_almost_full & list_rd_d1 & ~pf_rd);
    assign list_rd = init_done & ~list_empty & pf_room;
    assign pf_rd   = init_done & req_d1 & ~pf_empty;

    sync_fifo #(.T(buf_ptr_t), .DEPTH(BUF_NUM)) u_free_list (
        .clk        (clk),
        .rst        (list_rst),
        .wr         (list_wr),
        .din        (list_din),
        .rd         (list_rd),
        .dout       (list_dout),
        .count      (list_count),
        .full       (list_full),
        .almost_full(),
        .empty      (list_empty)
    );

    sync_fifo #(.T(buf_ptr_t), .DEPTH(PF_DEPTH)) u_prefetch (
        .clk        (clk),
        .rst        (list_rst),
        .wr         (list_rd_d1),
        .din        (list_dout_q),
        .rd         (pf_rd),
        .dout       (pf_dout),
        .count      (),
        .full       (pf_full),
        .almost_full(pf_almost_full),
        .empty      (pf_empty)
    );

    // ******************************
    // request pipeline and outputs
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            req_d1         <= 1'b0;
            free_buf_valid <= 1'b0;
            list_rd_d1     <= 1'b0;
            wr_valid_d1    <= 1'b0;
            enq_valid      <= 1'b0;
            alloc_inc      <= 1'b0;
            rel_inc        <= 1'b0;
        end else begin
            req_d1         <= free_buf_req;
            free_buf_valid <= req_d1;       // 2 cycles after the request
            list_rd_d1     <= list_rd;
            wr_valid_d1    <= wr_valid;
            enq_valid      <= wr_valid_d1 & ~wr_evt_d1.sop;
            alloc_inc      <= pf_rd;
            rel_inc        <= rel_pop;
        end
    end

    always_ff @(posedge clk) begin
        list_dout_q        <= list_dout;    // head at read time
        free_buf_available <= pf_rd;
        free_buf_ptr       <= pf_dout;
        wr_evt_d1          <= wr_evt;
        enq_evt.prev       <= last_ptr[wr_evt_d1.port];
        enq_evt.cur        <= wr_evt_d1.ptr;
        if (wr_valid_d1)
            last_ptr[wr_evt_d1.port] <= wr_evt_d1.ptr;   // per-port last buffer
    end

endmodule

// File: logic/link_table.sv
// Next-pointer table that chains the buffers of a packet.
// Each enqueue event writes next[prev] = cur on the edge it is seen.
// One read port, with the pointer valid the cycle after link_rd_en.
`timescale 1ns/10ps
`include "pktbuf_cfg.svh"

module link_table (
    input  logic                 clk,
    input  logic                 enq_valid,
    input  pktbuf_pkg::enq_evt_t enq_evt,
    input  logic                 link_rd_en,
    input  pktbuf_pkg::buf_ptr_t link_rd_addr,
    output pktbuf_pkg::buf_ptr_t link_rd_ptr
);
    import pktbuf_pkg::*;

    localparam int BUF_NUM = `PKTBUF_BUF_NUM;

    // one entry per buffer, holds the following buffer of the packet
    buf_ptr_t next_ptr [BUF_NUM];

    // ******************************
    // write port
    // ******************************
    always_ff @(posedge clk) begin
        if (enq_valid)
            next_ptr[enq_evt.prev] <= enq_evt.cur;
    end

    // ******************************
    // read port
    // ******************************
    // same-address write and read returns the old entry
    always_ff @(posedge clk) begin
        if (link_rd_en)
            link_rd_ptr <= next_ptr[link_rd_addr];
    end

endmodule

// File: logic/freeb_regs.sv
// Register block of the buffer manager.
// REG_CTRL bit 0 starts a free list init; REG_STATUS bit 0 is init_done.
// Allocation and release counters clear on reset and on init.
// Every access is acknowledged one cycle later, with read data.
`timescale 1ns/10ps

module freeb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  pktbuf_pkg::reg_req_t reg_req,
    output pktbuf_pkg::reg_rsp_t reg_rsp,
    output logic                 init_cmd,
    input  logic                 init_done,
    input  logic                 alloc_inc,
    input  logic                 rel_inc
);
    import pktbuf_pkg::*;

    logic        ctrl_wr;
    logic        rsp_ack;
    logic [31:0] rsp_rdata;
    logic [31:0] rd_data;
    logic [31:0] alloc_cnt;
    logic [31:0] rel_cnt;

    assign ctrl_wr = reg_req.valid & reg_req.write &
                     (reg_req.addr == REG_CTRL) & reg_req.wdata[0];

    // ******************************
    // read mux
    // ******************************
    always_comb begin
        rd_data = '0;
        case (reg_req.addr)
            REG_STATUS:    rd_data = {31'b0, init_done};
            REG_ALLOC_CNT: rd_data = alloc_cnt;
            REG_REL_CNT:   rd_data = rel_cnt;
            default:       rd_data = '0;    // ctrl reads back 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init_cmd  <= 1'b0;
            rsp_ack   <= 1'b0;
            alloc_cnt <= '0;
            rel_cnt   <= '0;
        end else begin
            init_cmd <= ctrl_wr;            // one-cycle pulse
            rsp_ack  <= reg_req.valid;
            if (ctrl_wr) begin
                alloc_cnt <= '0;
                rel_cnt   <= '0;
            end else begin
                alloc_cnt <= alloc_cnt + 32'(alloc_inc);
                rel_cnt   <= rel_cnt + 32'(rel_inc);
            end
        end
    end

    always_ff @(posedge clk) begin
        rsp_rdata <= rd_data;
    end

    assign reg_rsp = '{rdata: rsp_rdata, ack: rsp_ack};

endmodule

// File: logic/pktbuf_mgr_top.sv
// Top level of the packet buffer manager.
// The release queue absorbs credited releases until freeb_ctrl pops them.
// Each pop returns one credit to the sender on the same cycle.
`timescale 1ns/10ps
`include "pktbuf_cfg.svh"

module pktbuf_mgr_top (
    input  logic                 clk,
    input  logic                 rst,
    // allocation
    input  logic                 free_buf_req,
    output logic                 free_buf_valid,
    output logic                 free_buf_available,
    output pktbuf_pkg::buf_ptr_t free_buf_ptr,
    // write events
    input  logic                 wr_valid,
    input  pktbuf_pkg::wr_evt_t  wr_evt,
    output logic                 enq_valid,
    output pktbuf_pkg::enq_evt_t enq_evt,
    // release
    input  logic                 rel_valid,
    input  pktbuf_pkg::rel_req_t rel_req,
    output logic                 rel_credit,
    // register bus
    input  pktbuf_pkg::reg_req_t reg_req,
    output pktbuf_pkg::reg_rsp_t reg_rsp,
    // link lookup
    input  logic                 link_rd_en,
    input  pktbuf_pkg::buf_ptr_t link_rd_addr,
    output pktbuf_pkg::buf_ptr_t link_rd_ptr
);
    import pktbuf_pkg::*;

    rel_req_t rel_head;
    logic     rel_empty;
    logic     rel_pop;
    logic     init_cmd;
    logic     init_done;
    logic     alloc_inc;
    logic     rel_inc;

    assign rel_credit = rel_pop;

    // ******************************
    // release queue
    // ******************************
    sync_fifo #(.T(rel_req_t), .DEPTH(`PKTBUF_REL_CREDITS)) u_rel_q (
        .clk        (clk),
        .rst        (rst),
        .wr         (rel_valid),
        .din        (rel_req),
        .rd         (rel_pop),
        .dout       (rel_head),
        .count      (),
        .full       (),             // credits keep it from filling
        .almost_full(),
        .empty      (rel_empty)
    );

    freeb_ctrl u_freeb_ctrl (
        .clk               (clk),
        .rst               (rst),
        .init_cmd          (init_cmd),
        .free_buf_req      (free_buf_req),
        .free_buf_valid    (free_buf_valid),
        .free_buf_available(free_buf_available),
        .free_buf_ptr      (free_buf_ptr),
        .wr_valid          (wr_valid),
        .wr_evt            (wr_evt),
        .enq_valid         (enq_valid),
        .enq_evt           (enq_evt),
        .rel_empty         (rel_empty),
        .rel_head          (rel_head),
        .rel_pop           (rel_pop),
        .init_done         (init_done),
        .alloc_inc         (alloc_inc),
        .rel_inc           (rel_inc)
    );

    freeb_regs u_freeb_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .init_cmd (init_cmd),
        .init_done(init_done),
        .alloc_inc(alloc_inc),
        .rel_inc  (rel_inc)
    );

    link_table u_link_table (
        .clk         (clk),
        .enq_valid   (enq_valid),
        .enq_evt     (enq_evt),
        .link_rd_en  (link_rd_en),
        .link_rd_addr(link_rd_addr),
        .link_rd_ptr (link_rd_ptr)
    );

endmodule

// File: sim/tb_pktbuf_mgr.sv
// Directed testbench of the packet buffer manager.
// Covers init fill, allocation, credited release, link chaining and registers.
// Each test task drives pktbuf_mgr_top and checks its responses.
`timescale 1ns/10ps
`include "pktbuf_cfg.svh"

module tb_pktbuf_mgr;
    import pktbuf_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int BUF_NUM     = `PKTBUF_BUF_NUM;
    localparam int REL_CREDITS = `PKTBUF_REL_CREDITS;
    localparam int TEST_CYCLES = 60 + 2 + 40 + 20 + 80;    // tests 1 to 5
    localparam int WAIT_LIMIT  = 200;

    logic     clk = 1'b0;
    logic     rst;
    logic     free_buf_req;
    logic     free_buf_valid;
    logic     free_buf_available;
    buf_ptr_t free_buf_ptr;
    logic     wr_valid;
    wr_evt_t  wr_evt;
    logic     enq_valid;
    enq_evt_t enq_evt;
    logic     rel_valid;
    rel_req_t rel_req;
    logic     rel_credit;
    reg_req_t reg_req;
    reg_rsp_t reg_rsp;
    logic     link_rd_en;
    buf_ptr_t link_rd_addr;
    buf_ptr_t link_rd_ptr;

    int       credits_back = 0;     // rel_credit pulses seen
    int       rel_sent     = 0;
    int       n_alloc      = 0;     // allocations expected to succeed
    int       n_rel        = 0;
    int       cycle_cnt    = 0;     // rising edges so far
    buf_ptr_t order [BUF_NUM];      // shuffled release order
    enq_evt_t enq_seen [$];         // link events in arrival order
    int       enq_at [$];           // cycle of each link event

    pktbuf_mgr_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
        cycle_cnt++;

    // combinational pop, stable by the falling edge
    always @(negedge clk) begin
        if (!rst && rel_credit)
            credits_back++;
        if (!rst && enq_valid) begin
            enq_seen.push_back(enq_evt);
            enq_at.push_back(cycle_cnt);
        end
    end

    initial begin
        #(20 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", 20 * TEST_CYCLES);
        stop_run();
    end

    // ******************************
    // compare tasks
    // ******************************
    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_ptr(input string name, input buf_ptr_t exp, input buf_ptr_t got);
        if (got !== exp) begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail t=%0t %s expected %b got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        if (got !== exp) begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_enq(input string name, input enq_evt_t exp, input enq_evt_t got);
        if (got !== exp) begin
            $display("Fail t=%0t %s expected %h/%h got %h/%h", $time, name,
                     exp.prev, exp.cur, got.prev, got.cur);
            stop_run();
        end
    endtask

    // ******************************
    // driver tasks
    // ******************************
    task automatic alloc_check(input logic exp_avail, input buf_ptr_t exp_ptr);
        free_buf_req = 1'b1;
        @(posedge clk);
        #1;
        free_buf_req = 1'b0;
        check_bit("free_buf_valid", 1'b0, free_buf_valid);     // not after 1 cycle
        @(posedge clk);
        #1;
        check_bit("free_buf_valid", 1'b1, free_buf_valid);
        check_bit("free_buf_available", exp_avail, free_buf_available);
        if (exp_avail) begin
            check_ptr("free_buf_ptr", exp_ptr, free_buf_ptr);
            n_alloc++;
        end
    endtask

    task automatic send_release(input buf_ptr_t ptr, input port_id_t port);
        int waited;
        waited = 0;
        while (REL_CREDITS - rel_sent + credits_back < 1) begin    // out of credits
            if (waited == WAIT_LIMIT) begin
                $display("no release credit came back to send pointer %h", ptr);
                stop_run();
            end
            waited++;
            @(posedge clk);
            #1;
        end
        rel_valid    = 1'b1;
        rel_req.ptr  = ptr;
        rel_req.port = port;
        @(posedge clk);
        #1;
        rel_valid = 1'b0;
        rel_sent++;
        n_rel++;
    endtask

    task automatic wait_credits();
        int waited;
        waited = 0;
        while (credits_back != rel_sent) begin
            if (waited == WAIT_LIMIT) begin
                $display("only %0d of %0d release credits came back", credits_back, rel_sent);
                stop_run();
            end
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reg_access(input logic write, input reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        reg_req.valid = 1'b1;
        reg_req.write = write;
        reg_req.addr  = addr;
        reg_req.wdata = wdata;
        @(posedge clk);
        #1;
        reg_req = '0;
        check_bit("reg_rsp.ack", 1'b1, reg_rsp.ack);
        rdata = reg_rsp.rdata;
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        reg_access(1'b0, addr, '0, data);
        check_word(name, exp, data);
    endtask

    // polls status; no credit may return while init runs
    task automatic wait_init_done();
        int          start;
        int          polls;
        logic [31:0] status;
        start = credits_back;
        polls = 0;
        reg_access(1'b0, REG_STATUS, '0, status);
        while (status[0] !== 1'b1) begin
            check_word("rel_credit pulses", 32'(start), 32'(credits_back));
            if (polls == WAIT_LIMIT) begin
                $display("init_done never rose");
                stop_run();
            end
            polls++;
            reg_access(1'b0, REG_STATUS, '0, status);
        end
    endtask

    task automatic write_evt(input buf_ptr_t ptr, input port_id_t port, input logic sop,
                             output int at);
        at          = cycle_cnt;    // cycle the event is driven in
        wr_valid    = 1'b1;
        wr_evt.ptr  = ptr;
        wr_evt.port = port;
        wr_evt.sop  = sop;
        @(posedge clk);
        #1;
        wr_valid = 1'b0;
    endtask

    task automatic link_lookup(input buf_ptr_t addr, output buf_ptr_t ptr);
        link_rd_en   = 1'b1;
        link_rd_addr = addr;
        @(posedge clk);
        #1;
        link_rd_en = 1'b0;
        ptr = link_rd_ptr;
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic test_init_alloc();
        check_bit("free_buf_valid", 1'b0, free_buf_valid);
        check_bit("enq_valid", 1'b0, enq_valid);
        check_bit("rel_credit", 1'b0, rel_credit);
        check_bit("reg_rsp.ack", 1'b0, reg_rsp.ack);
        wait_init_done();
        for (int i = 0; i < BUF_NUM; i++)
            alloc_check(1'b1, buf_ptr_t'(i));           // list filled in order
    endtask

    task automatic test_release();
        int       j;
        buf_ptr_t tmp;
        for (int i = 0; i < BUF_NUM; i++)
            order[i] = buf_ptr_t'(i);
        for (int i = BUF_NUM - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++)
            send_release(order[i], port_id_t'(i));
        wait_credits();
        for (int i = 0; i < 8; i++)
            alloc_check(1'b1, order[i]);                // back in release order
    endtask

    task automatic test_links();
        buf_ptr_t got;
        int       at;
        enq_evt_t evt;
        enq_evt_t exp_evt [$];
        int       exp_at [$];
        enq_seen.delete();
        enq_at.delete();
        // port 0 chains order[0..2], port 1 chains order[3..5]
        for (int i = 0; i < 3; i++) begin
            write_evt(order[i], 2'd0, i == 0, at);
            if (i > 0) begin
                evt.prev = order[i - 1];
                evt.cur  = order[i];
                exp_evt.push_back(evt);
                exp_at.push_back(at + 2);               // link event 2 cycles later
            end
            write_evt(order[i + 3], 2'd1, i == 0, at);
            if (i > 0) begin
                evt.prev = order[i + 2];
                evt.cur  = order[i + 3];
                exp_evt.push_back(evt);
                exp_at.push_back(at + 2);
            end
        end
        repeat (3) @(posedge clk);                      // enqueue lands 2 cycles later
        #1;
        check_word("enq_valid pulses", 32'(exp_evt.size()), 32'(enq_seen.size()));
        for (int i = 0; i < exp_evt.size(); i++) begin
            check_enq("enq_evt", exp_evt[i], enq_seen[i]);
            check_word("enq_valid cycle", 32'(exp_at[i]), 32'(enq_at[i]));
        end
        for (int i = 0; i < 2; i++) begin
            link_lookup(order[i], got);
            check_ptr("link_rd_ptr", order[i + 1], got);
            link_lookup(order[i + 3], got);
            check_ptr("link_rd_ptr", order[i + 4], got);
        end
    endtask

    task automatic test_reinit();
        logic [31:0] unused;
        check_reg(REG_ALLOC_CNT, 32'(n_alloc), "alloc_cnt");
        check_reg(REG_REL_CNT, 32'(n_rel), "rel_cnt");
        reg_access(1'b1, REG_CTRL, 32'd1, unused);
        n_alloc = 0;
        n_rel   = 0;
        send_release(order[8], 2'd0);
        send_release(order[9], 2'd1);
        check_reg(REG_STATUS, 32'd0, "status");
        check_reg(REG_ALLOC_CNT, 32'd0, "alloc_cnt");
        check_reg(REG_REL_CNT, 32'd0, "rel_cnt");
        wait_init_done();
        wait_credits();
        for (int i = 0; i < BUF_NUM; i++)
            alloc_check(1'b1, buf_ptr_t'(i));
        alloc_check(1'b1, order[8]);                    // releases at the tail
        alloc_check(1'b1, order[9]);
        repeat (2) @(posedge clk);                      // let the counters settle
        #1;
        check_reg(REG_ALLOC_CNT, 32'(n_alloc), "alloc_cnt");
        check_reg(REG_REL_CNT, 32'(n_rel), "rel_cnt");
    endtask

    initial begin
        rst          = 1'b1;
        free_buf_req = 1'b0;
        wr_valid     = 1'b0;
        wr_evt       = '0;
        rel_valid    = 1'b0;
        rel_req      = '0;
        reg_req      = '0;
        link_rd_en   = 1'b0;
        link_rd_addr = '0;
        void'($urandom(32'hbe57));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_init_alloc();
        alloc_check(1'b0, '0);                          // list is empty now
        test_release();
        test_links();
        test_reinit();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: pktbuf.f
+incdir+include
logic/pktbuf_pkg.sv
logic/sync_fifo.sv
logic/freeb_ctrl.sv
logic/link_table.sv
logic/freeb_regs.sv
logic/pktbuf_mgr_top.sv
sim/tb_pktbuf_mgr.sv

// File: Bender.yml
package:
  name: pktbuf

export_include_dirs:
  - include

sources:
  - logic/pktbuf_pkg.sv
  - logic/sync_fifo.sv
  - logic/freeb_ctrl.sv
  - logic/link_table.sv
  - logic/freeb_regs.sv
  - logic/pktbuf_mgr_top.sv
  - target: simulation
    files:
      - sim/tb_pktbuf_mgr.sv
